//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_scroll_dma
FILELIST = list.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- dma_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module dma_sequencer (
    input  wire        clk,
    input  wire        rst,
    input  wire        hb,
    input  wire        bg,
    input  wire  [8:0] vrender,
    input  wire [15:0] vpos1,
    input  wire [15:0] vpos2,
    input  wire [15:0] vpos3,
    input  wire        header_done,
    output logic       header_start,
    output logic [2:0] swap_mask,
    output logic       br,
    fetch_if.seq       fetch
);

    logic        last_hb;
    logic        hb_edge;
    logic [15:0] vline;
    logic [15:0] vscr1;
    logic [15:0] vscr2;
    logic [15:0] vscr3;
    logic  [2:0] sel;
    logic  [2:0] pending;
    logic  [2:0] left;
    logic  [2:0] swap_acc;
    logic  [2:0] state;

    assign hb_edge = hb & ~last_hb;

    // Vertical scroll sums for the line being prepared
    assign vscr1 = vpos1 + vline;
    assign vscr2 = vpos2 + vline;
    assign vscr3 = vpos3 + vline;

    // Only rows starting on a tile boundary need a fresh fetch
    assign sel[0] = (vscr1[2:0] == 3'd0);
    assign sel[1] = (vscr2[3:0] == 4'd0);
    assign sel[2] = (vscr3[3:0] == 4'd0);

    assign left = pending & ~(3'b001 << fetch.layer);

    assign br = (state == scroll_pkg::ST_HEADER) ||
                (state == scroll_pkg::ST_PICK)   ||
                (state == scroll_pkg::ST_FETCH);

    // Target line is one ahead of the render counter
    always_ff @(posedge clk) begin
        if (hb_edge) begin
            vline <= {7'd0, vrender} + 16'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_hb      <= 1'b0;
            header_start <= 1'b0;
            swap_mask    <= 3'b000;
            swap_acc     <= 3'b000;
            pending      <= 3'b000;
            state        <= scroll_pkg::ST_IDLE;
            fetch.load   <= 1'b0;
            fetch.layer  <= scroll_pkg::LAYER1;
        end else begin
            last_hb      <= hb;
            header_start <= hb_edge;
            swap_mask    <= 3'b000;
            fetch.load   <= 1'b0;
            if (hb_edge) begin
                // Banks filled during the last line go live now
                swap_mask <= swap_acc;
                swap_acc  <= 3'b000;
                pending   <= 3'b000;
                state     <= scroll_pkg::ST_HEADER;
            end else begin
                case (state)
                    scroll_pkg::ST_HEADER: begin
                        if (header_done) begin
                            pending <= sel;
                            state   <= scroll_pkg::ST_PICK;
                        end
                    end
                    scroll_pkg::ST_PICK: begin
                        if (pending == 3'b000) begin
                            state <= scroll_pkg::ST_DONE;
                        end else if (bg) begin
                            fetch.load <= 1'b1;
                            state      <= scroll_pkg::ST_FETCH;
                            // Lowest pending layer goes first
                            if (pending[0]) begin
                                fetch.layer <= scroll_pkg::LAYER1;
                                swap_acc[0] <= 1'b1;
                            end else if (pending[1]) begin
                                fetch.layer <= scroll_pkg::LAYER2;
                                swap_acc[1] <= 1'b1;
                            end else begin
                                fetch.layer <= scroll_pkg::LAYER3;
                                swap_acc[2] <= 1'b1;
                            end
                        end
                    end
                    scroll_pkg::ST_FETCH: begin
                        if (fetch.last && fetch.word_done) begin
                            pending <= left;
                            state   <= (left == 3'b000) ? scroll_pkg::ST_DONE
                                                        : scroll_pkg::ST_PICK;
                        end
                    end
                    scroll_pkg::ST_DONE: begin
                        state <= scroll_pkg::ST_IDLE;
                    end
                    default: begin
                        state <= scroll_pkg::ST_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- fetch_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_if;

    // Layer under fetch and its start strobe
    logic [1:0] layer;
    logic       load;

    // Word progress
    logic       addr_phase;
    logic       word_done;
    logic       last;
    logic [scroll_pkg::CACHE_AW-1:0] entry;

    logic [scroll_pkg::VADDR_W:1] vram_addr;
    logic       cache_wr;

    modport seq (output layer, load, input last, word_done);

    modport timer (
        output entry, addr_phase, last, word_done,
        input  load, layer, cache_wr
    );

    modport addr (output vram_addr, input load, layer, entry, addr_phase);

    modport cache (output cache_wr, input entry, layer, addr_phase);

endinterface

`default_nettype wire

//--- list.f
scroll_pkg.sv
fetch_if.sv
dma_sequencer.sv
slot_timer.sv
tile_addr_gen.sv
tile_cache.sv
scroll_dma.sv
tb_vram_model.sv
tb_scroll_dma.sv

//--- scroll_dma.sv
`timescale 1ns/1ps
`default_nettype none

module scroll_dma (
    input  wire         clk,
    input  wire         rst,
    input  wire         pxl_cen,
    input  wire         hb,
    input  wire   [8:0] vrender,
    input  wire  [15:0] vram1_base,
    input  wire  [15:0] hpos1,
    input  wire  [15:0] vpos1,
    input  wire  [15:0] vram2_base,
    input  wire  [15:0] hpos2,
    input  wire  [15:0] vpos2,
    input  wire  [15:0] vram3_base,
    input  wire  [15:0] hpos3,
    input  wire  [15:0] vpos3,
    input  wire   [7:0] tile_addr,
    output logic [15:0] tile_data,
    output logic [17:1] vram_addr,
    input  wire  [15:0] vram_data,
    input  wire         vram_ok,
    output logic        vram_cs,
    output logic        br,
    input  wire         bg
);

    logic       header_start;
    logic       header_done;
    logic [2:0] swap_mask;

    fetch_if u_fetch ();

    // Chip select follows the bus request
    assign vram_cs = br;

    dma_sequencer u_seq (
        .clk          (clk),
        .rst          (rst),
        .hb           (hb),
        .bg           (bg),
        .vrender      (vrender),
        .vpos1        (vpos1),
        .vpos2        (vpos2),
        .vpos3        (vpos3),
        .header_done  (header_done),
        .header_start (header_start),
        .swap_mask    (swap_mask),
        .br           (br),
        .fetch        (u_fetch.seq)
    );

    slot_timer u_timer (
        .clk          (clk),
        .rst          (rst),
        .pxl_cen      (pxl_cen),
        .bg           (bg),
        .vram_ok      (vram_ok),
        .header_start (header_start),
        .header_done  (header_done),
        .fetch        (u_fetch.timer)
    );

    tile_addr_gen u_addr (
        .clk        (clk),
        .rst        (rst),
        .vrender    (vrender),
        .hpos1      (hpos1),
        .hpos2      (hpos2),
        .hpos3      (hpos3),
        .vpos1      (vpos1),
        .vpos2      (vpos2),
        .vpos3      (vpos3),
        .vram1_base (vram1_base),
        .vram2_base (vram2_base),
        .vram3_base (vram3_base),
        .fetch      (u_fetch.addr),
        .vram_addr  (vram_addr)
    );

    tile_cache u_cache (
        .clk       (clk),
        .rst       (rst),
        .vram_data (vram_data),
        .vram_ok   (vram_ok),
        .swap_mask (swap_mask),
        .tile_addr (tile_addr),
        .tile_data (tile_data),
        .fetch     (u_fetch.cache)
    );

endmodule

`default_nettype wire

//--- scroll_pkg.sv
`default_nettype none

package scroll_pkg;

    // Bus and cache sizes
    localparam int CACHE_AW = 8;
    localparam int WORD_W   = 16;
    localparam int VADDR_W  = 17;

    // Cache entries per layer, two entries per tile
    localparam logic [7:0] SCR1_FIRST = 8'd0;
    localparam logic [7:0] SCR1_LAST  = 8'd99;
    localparam logic [7:0] SCR2_FIRST = 8'd128;
    localparam logic [7:0] SCR2_LAST  = 8'd225;
    localparam logic [7:0] SCR3_FIRST = 8'd226;
    localparam logic [7:0] SCR3_LAST  = 8'd255;

    // Horizontal start offsets
    localparam logic [10:0] HOFS1 = 11'h038;
    localparam logic [10:0] HOFS2 = 11'h030;
    localparam logic [10:0] HOFS3 = 11'h020;

    // Tile widths in pixels
    localparam logic [10:0] HSTEP1 = 11'd8;
    localparam logic [10:0] HSTEP2 = 11'd16;
    localparam logic [10:0] HSTEP3 = 11'd32;

    // Line header length in pixel enables
    localparam int LINE_WAIT = 16;

    localparam logic [1:0] LAYER1 = 2'd0;
    localparam logic [1:0] LAYER2 = 2'd1;
    localparam logic [1:0] LAYER3 = 2'd2;

    // Sequencer states
    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_HEADER = 3'd1;
    localparam logic [2:0] ST_PICK   = 3'd2;
    localparam logic [2:0] ST_FETCH  = 3'd3;
    localparam logic [2:0] ST_DONE   = 3'd4;

endpackage

`default_nettype wire

//--- slot_timer.sv
`timescale 1ns/1ps
`default_nettype none

module slot_timer (
    input  wire  clk,
    input  wire  rst,
    input  wire  pxl_cen,
    input  wire  bg,
    input  wire  vram_ok,
    input  wire  header_start,
    output logic header_done,
    fetch_if.timer fetch
);

    // Header pulses, or {entry, phase} during a fetch
    logic [scroll_pkg::CACHE_AW:0]   cnt;
    logic [scroll_pkg::CACHE_AW-1:0] first_entry;
    logic [scroll_pkg::CACHE_AW-1:0] last_entry;
    logic hdr_busy;
    logic fetching;
    logic presented;
    logic wr_seen;
    logic step;

    assign step = bg & pxl_cen;

    always_comb begin
        case (fetch.layer)
            scroll_pkg::LAYER1: begin
                first_entry = scroll_pkg::SCR1_FIRST;
                last_entry  = scroll_pkg::SCR1_LAST;
            end
            scroll_pkg::LAYER2: begin
                first_entry = scroll_pkg::SCR2_FIRST;
                last_entry  = scroll_pkg::SCR2_LAST;
            end
            default: begin
                first_entry = scroll_pkg::SCR3_FIRST;
                last_entry  = scroll_pkg::SCR3_LAST;
            end
        endcase
    end

    assign fetch.entry      = cnt[scroll_pkg::CACHE_AW:1];
    assign fetch.addr_phase = fetching & ~cnt[0];
    assign fetch.last       = fetching & (fetch.entry == last_entry);

    // Word retires on the step after its cache write, while last still holds
    assign fetch.word_done  = fetching & cnt[0] & step & wr_seen;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt             <= '0;
            hdr_busy        <= 1'b0;
            fetching        <= 1'b0;
            presented       <= 1'b0;
            wr_seen         <= 1'b0;
            header_done     <= 1'b0;
        end else begin
            header_done     <= 1'b0;
            if (fetch.cache_wr) begin
                wr_seen <= 1'b1;
            end
            if (header_start) begin
                cnt      <= '0;
                hdr_busy <= 1'b1;
                fetching <= 1'b0;
            end else if (fetch.load) begin
                cnt       <= {first_entry, 1'b0};
                fetching  <= 1'b1;
                presented <= 1'b0;
                wr_seen   <= 1'b0;
            end else if (hdr_busy) begin
                if (step) begin
                    cnt <= cnt + 1'b1;
                    if (cnt == (scroll_pkg::CACHE_AW+1)'(scroll_pkg::LINE_WAIT - 1)) begin
                        hdr_busy    <= 1'b0;
                        header_done <= 1'b1;
                    end
                end
            end else if (fetching) begin
                if (!cnt[0]) begin
                    // Address must have been out for a cycle before the data phase
                    if (step && presented) begin
                        cnt       <= cnt + 1'b1;
                        presented <= 1'b0;
                    end else begin
                        presented <= 1'b1;
                    end
                end else if (step && wr_seen) begin
                    cnt             <= cnt + 1'b1;
                    wr_seen         <= 1'b0;
                    if (fetch.last) begin
                        fetching <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_scroll_dma.sv
`timescale 1ns/1ps
`default_nettype none

module tb_scroll_dma;

    localparam int      NUM_LINES   = 10;
    localparam int      LINE_CYCLES = 3000;
    localparam longint  CLK_PERIOD  = 100;

    logic        clk;
    logic        rst;
    logic        pxl_cen;
    logic        hb;
    logic  [8:0] vrender;
    logic [15:0] base [3];
    logic [15:0] hpos [3];
    logic [15:0] vpos [3];
    logic  [7:0] tile_addr;
    wire  [15:0] tile_data;
    wire  [17:1] vram_addr;
    wire  [15:0] vram_data;
    wire         vram_ok;
    wire         vram_cs;
    wire         br;
    wire         bg;
    logic [31:0] bg_delay;

    integer      seed;
    int          errors;
    logic [15:0] exp_mem [256];
    logic [15:0] pend_mem [256];
    logic        exp_valid [3];
    logic        pend_sel [3];

    // Comparator pipeline
    logic        drv_valid;
    logic [15:0] drv_exp;
    logic        cur_valid;
    logic [15:0] cur_exp;
    logic  [7:0] cur_addr;

    scroll_dma u_scroll_dma (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .hb(hb), .vrender(vrender),
        .vram1_base(base[0]), .hpos1(hpos[0]), .vpos1(vpos[0]),
        .vram2_base(base[1]), .hpos2(hpos[1]), .vpos2(vpos[1]),
        .vram3_base(base[2]), .hpos3(hpos[2]), .vpos3(vpos[2]),
        .tile_addr(tile_addr), .tile_data(tile_data), .vram_addr(vram_addr),
        .vram_data(vram_data), .vram_ok(vram_ok), .vram_cs(vram_cs),
        .br(br), .bg(bg)
    );

    tb_vram_model u_vram (
        .clk(clk), .rst(rst), .vram_addr(vram_addr), .vram_cs(vram_cs), .br(br),
        .bg_delay(bg_delay), .vram_data(vram_data), .vram_ok(vram_ok), .bg(bg)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Pixel enable on every other cycle
    always @(posedge clk) begin
        #1 pxl_cen = ~pxl_cen;
    end

    function automatic int first_entry(input int layer);
        return (layer == 0) ? 0 : (layer == 1) ? 128 : 226;
    endfunction

    function automatic int last_entry(input int layer);
        return (layer == 0) ? 99 : (layer == 1) ? 225 : 255;
    endfunction

    // Expected cache word from the scroll and scan rules
    function automatic logic [15:0] expected_entry(input int layer, input logic [15:0] vp,
            input logic [15:0] hp, input logic [15:0] bs, input logic [8:0] vr, input int idx);
        logic [15:0] vs;
        logic [10:0] vn;
        logic [10:0] hn;
        logic [10:0] step;
        logic [10:0] ofs;
        logic [11:0] scan;
        logic [16:0] a;
        logic        w;
        int          off;
        vs   = vp + {7'd0, vr} + 16'd1;
        vn   = vs[10:0];
        step = (layer == 0) ? 11'd8 : (layer == 1) ? 11'd16 : 11'd32;
        ofs  = (layer == 0) ? 11'h38 : (layer == 1) ? 11'h30 : 11'h20;
        off  = idx - first_entry(layer);
        w    = 1'(off % 2);
        hn   = ofs + (hp[10:0] & ~(step - 11'd1)) + 11'(off / 2) * step;
        if (layer == 0) begin
            scan = {vn[8], hn[8:3], vn[7:3]};
        end else if (layer == 1) begin
            scan = {vn[9:8], hn[9:4], vn[7:4]};
        end else begin
            scan = {vn[10:8], hn[10:5], vn[7:5]};
        end
        a = {bs[9:1], 8'd0} + {4'd0, scan, w};
        return a[15:0] ^ 16'h5a5a;
    endfunction

    always @(posedge clk) begin
        cur_valid <= drv_valid;
        cur_exp   <= drv_exp;
        cur_addr  <= tile_addr;
    end

    // tile_data is stable by the falling edge
    always @(negedge clk) begin
        if (cur_valid) begin
            assert (tile_data === cur_exp) else begin
                errors++;
                $display("Fail at %0t: tile_data[%0d] expected %h actual %h",
                         $time, cur_addr, cur_exp, tile_data);
            end
        end
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // Aligned layers get a vertical sum that is a multiple of 16
    task automatic set_scroll(input logic [2:0] aligned);
        logic [15:0] vline;
        logic [15:0] v;
        vrender = 9'($random(seed));
        vline   = {7'd0, vrender} + 16'd1;
        for (int l = 0; l < 3; l++) begin
            base[l] = 16'($random(seed));
            hpos[l] = 16'($random(seed));
            v       = 16'($random(seed));
            vpos[l] = (aligned[l] ? {v[15:4], 4'b0000} : {v[15:4], 4'b0100}) - vline;
        end
    endtask

    // hb edge, then the layers fetched last line go live
    task automatic start_line();
        hb = 1'b1;
        tick();
        hb = 1'b0;
        for (int l = 0; l < 3; l++) begin
            if (pend_sel[l]) begin
                for (int i = first_entry(l); i <= last_entry(l); i++) begin
                    exp_mem[i] = pend_mem[i];
                end
                exp_valid[l] = 1'b1;
                pend_sel[l]  = 1'b0;
            end
        end
        tick();
        tick();
    endtask

    task automatic sweep_cache();
        int l;
        for (int a = 0; a < 256; a++) begin
            l = (a <= 99) ? 0 : (a < 128) ? -1 : (a <= 225) ? 1 : 2;
            tile_addr = 8'(a);
            drv_exp   = exp_mem[a];
            drv_valid = (l >= 0) ? exp_valid[l] : 1'b0;
            tick();
        end
        drv_valid = 1'b0;
        tick();
        tick();
    endtask

    task automatic run_line(input int delay);
        logic [15:0] vs;
        bg_delay = 32'(delay);
        start_line();
        while (!br) tick();
        // Held-off grant must not drop the request
        while (!bg) begin
            assert (br === 1'b1) else begin
                errors++;
                $display("Fail at %0t: br expected 1 actual %b", $time, br);
            end
            tick();
        end
        sweep_cache();
        while (br) tick();
        for (int l = 0; l < 3; l++) begin
            vs = vpos[l] + {7'd0, vrender} + 16'd1;
            pend_sel[l] = (l == 0) ? (vs[2:0] == 3'd0) : (vs[3:0] == 4'd0);
            if (pend_sel[l]) begin
                for (int i = first_entry(l); i <= last_entry(l); i++) begin
                    pend_mem[i] = expected_entry(l, vpos[l], hpos[l], base[l], vrender, i);
                end
            end
        end
    endtask

    initial begin
        seed      = 32'he99a;
        errors    = 0;
        rst       = 1'b1;
        pxl_cen   = 1'b0;
        hb        = 1'b0;
        vrender   = 9'd0;
        tile_addr = 8'd0;
        drv_valid = 1'b0;
        drv_exp   = 16'd0;
        bg_delay  = 32'd1;
        for (int l = 0; l < 3; l++) begin
            base[l]      = 16'd0;
            hpos[l]      = 16'd0;
            vpos[l]      = 16'd0;
            exp_valid[l] = 1'b0;
            pend_sel[l]  = 1'b0;
        end
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        repeat (20) begin
            assert (br === 1'b0) else begin
                errors++;
                $display("Fail at %0t: br expected 0 actual %b", $time, br);
            end
            assert (vram_cs === 1'b0) else begin
                errors++;
                $display("Fail at %0t: vram_cs expected 0 actual %b", $time, vram_cs);
            end
            tick();
        end
        set_scroll(3'b111);
        run_line(1);
        set_scroll(3'b001);
        run_line(1);
        set_scroll(3'b111);
        run_line(200);
        repeat (4) begin
            set_scroll(3'b111);
            run_line(1);
        end
        // Last swap and check
        start_line();
        sweep_cache();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(NUM_LINES * LINE_CYCLES * CLK_PERIOD);
        $display("Run timed out before all lines were checked");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_vram_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vram_model (
    input  wire         clk,
    input  wire         rst,
    input  wire  [17:1] vram_addr,
    input  wire         vram_cs,
    input  wire         br,
    input  wire  [31:0] bg_delay,
    output logic [15:0] vram_data,
    output logic        vram_ok,
    output logic        bg
);

    integer      seed;
    logic [17:1] held;
    logic  [1:0] wait_cnt;
    logic [31:0] grant_cnt;

    initial seed = 32'he99a;

    // Data is a pure function of the word address
    assign vram_data = held[16:1] ^ 16'h5a5a;

    // A new address drops vram_ok for 0 to 3 extra cycles
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            held     <= '0;
            wait_cnt <= 2'd0;
            vram_ok  <= 1'b0;
        end else if (!vram_cs) begin
            vram_ok <= 1'b0;
        end else if (vram_addr != held) begin
            held     <= vram_addr;
            wait_cnt <= 2'($random(seed));
            vram_ok  <= 1'b0;
        end else if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end else begin
            vram_ok <= 1'b1;
        end
    end

    // Grant follows request after bg_delay cycles
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            bg        <= 1'b0;
            grant_cnt <= 32'd0;
        end else if (!br) begin
            bg        <= 1'b0;
            grant_cnt <= 32'd0;
        end else if (grant_cnt < bg_delay) begin
            grant_cnt <= grant_cnt + 32'd1;
        end else begin
            bg <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- tile_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tile_addr_gen (
    input  wire        clk,
    input  wire        rst,
    input  wire  [8:0] vrender,
    input  wire [15:0] hpos1,
    input  wire [15:0] hpos2,
    input  wire [15:0] hpos3,
    input  wire [15:0] vpos1,
    input  wire [15:0] vpos2,
    input  wire [15:0] vpos3,
    input  wire [15:0] vram1_base,
    input  wire [15:0] vram2_base,
    input  wire [15:0] vram3_base,
    fetch_if.addr      fetch,
    output logic [scroll_pkg::VADDR_W:1] vram_addr
);

    logic [15:0] vline;
    logic [15:0] vsum;
    logic [15:0] base;
    logic [10:0] hstart;
    logic [10:0] hstep;
    logic [10:0] vn;
    logic [10:0] hn;
    logic [11:0] scan;
    logic        last_ap;
    logic        attr_done;

    assign vline = {7'd0, vrender} + 16'd1;

    // Per-layer scroll and scan arrangement
    always_comb begin
        case (fetch.layer)
            scroll_pkg::LAYER1: begin
                vsum   = vpos1 + vline;
                hstart = scroll_pkg::HOFS1 + (hpos1[10:0] & ~(scroll_pkg::HSTEP1 - 11'd1));
                hstep  = scroll_pkg::HSTEP1;
                base   = vram1_base;
                scan   = {vn[8], hn[8:3], vn[7:3]};
            end
            scroll_pkg::LAYER2: begin
                vsum   = vpos2 + vline;
                hstart = scroll_pkg::HOFS2 + (hpos2[10:0] & ~(scroll_pkg::HSTEP2 - 11'd1));
                hstep  = scroll_pkg::HSTEP2;
                base   = vram2_base;
                scan   = {vn[9:8], hn[9:4], vn[7:4]};
            end
            default: begin
                vsum   = vpos3 + vline;
                hstart = scroll_pkg::HOFS3 + (hpos3[10:0] & ~(scroll_pkg::HSTEP3 - 11'd1));
                hstep  = scroll_pkg::HSTEP3;
                base   = vram3_base;
                scan   = {vn[10:8], hn[10:5], vn[7:5]};
            end
        endcase
    end

    // Attribute address latched, so the next tile can be addressed
    assign attr_done = last_ap & ~fetch.addr_phase & fetch.entry[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_ap <= 1'b0;
        end else begin
            last_ap <= fetch.addr_phase;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch.load) begin
            vn <= vsum[10:0];
            hn <= hstart;
        end else if (attr_done) begin
            hn <= hn + hstep;
        end
        // Word select is the low entry bit
        if (fetch.addr_phase) begin
            vram_addr <= {base[9:1], 8'd0} + {4'd0, scan, fetch.entry[0]};
        end
    end

    assign fetch.vram_addr = vram_addr;

endmodule

`default_nettype wire

//--- tile_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tile_cache (
    input  wire  clk,
    input  wire  rst,
    input  wire  [scroll_pkg::WORD_W-1:0]   vram_data,
    input  wire  vram_ok,
    input  wire  [2:0]                      swap_mask,
    input  wire  [scroll_pkg::CACHE_AW-1:0] tile_addr,
    output logic [scroll_pkg::WORD_W-1:0]   tile_data,
    fetch_if.cache fetch
);

    // Two banks of 256 words, bank select is the top address bit
    logic [scroll_pkg::WORD_W-1:0] mem [2**(scroll_pkg::CACHE_AW+1)];
    logic [scroll_pkg::WORD_W-1:0] wr_data;
    logic [2:0] active;
    logic       armed;
    logic       wr_bank;
    logic       rd_bank;

    // Writes go to the bank the renderer is not using
    assign wr_bank = ~active[fetch.layer];

    // Entries 100 to 127 are unused and fall in layer 1
    always_comb begin
        if (tile_addr < scroll_pkg::SCR2_FIRST) begin
            rd_bank = active[0];
        end else if (tile_addr <= scroll_pkg::SCR2_LAST) begin
            rd_bank = active[1];
        end else begin
            rd_bank = active[2];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active         <= 3'b000;
            armed          <= 1'b0;
            fetch.cache_wr <= 1'b0;
        end else begin
            active         <= active ^ swap_mask;
            fetch.cache_wr <= 1'b0;
            if (fetch.addr_phase) begin
                armed <= 1'b1;
            end else if (armed && vram_ok) begin
                // One write per presented address
                armed          <= 1'b0;
                fetch.cache_wr <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!fetch.addr_phase && armed && vram_ok) begin
            wr_data <= vram_data;
        end
        if (fetch.cache_wr) begin
            mem[{wr_bank, fetch.entry}] <= wr_data;
        end
        tile_data <= mem[{rd_bank, tile_addr}];
    end

endmodule

`default_nettype wire
